// ==== rtl/bp_cfg.svh ====
//////////////////////////////////////////////////
// Predictor sizes. BP_BTB_ENTRIES must be a power of two
// and BP_XLEN must stay above the BTB index bits plus two
//////////////////////////////////////////////////
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// PC and data width
`define BP_XLEN 32

// Return stack entries
`define BP_RSB_DEPTH 4

// BTB entries, direct mapped
`define BP_BTB_ENTRIES 16

// BTB index width, taken from PC bits above bit 1
`define BP_BTB_IDX_W ($clog2(`BP_BTB_ENTRIES))

// Tag keeps all PC bits above the index
`define BP_BTB_TAG_W (`BP_XLEN - `BP_BTB_IDX_W - 2)

`endif

// ==== rtl/bp_pkg.sv ====
//////////////////////////////////////////////////
// Vector types shared by the predictor blocks
// Widths follow bp_cfg.svh
//////////////////////////////////////////////////
`include "bp_cfg.svh"

package bp_pkg;

  ////////////////////////////////////////////////
  // Address and instruction words
  ////////////////////////////////////////////////

  // Fetch and target address
  typedef logic [`BP_XLEN-1:0] pc_t;

  // Uncompressed instruction only
  typedef logic [31:0] instr_t;

  ////////////////////////////////////////////////
  // BTB fields
  ////////////////////////////////////////////////

  // Index bits sit just above the word offset
  typedef logic [`BP_BTB_IDX_W-1:0] btb_idx_t;

  // Remaining upper PC bits
  typedef logic [`BP_BTB_TAG_W-1:0] btb_tag_t;

endpackage

// ==== rtl/bp_link_decode.sv ====
//////////////////////////////////////////////////
// JAL/JALR predecode with link hints on x1/x5
// Expects 32-bit uncompressed instructions only
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bp_cfg.svh"

module bp_link_decode import bp_pkg::*; (
  input  instr_t fetch_instr_i,
  input  pc_t    fetch_pc_i,
  output logic   push_o,
  output logic   pop_o,
  output logic   is_jal_o,
  output logic   is_jalr_o,
  output pc_t    link_addr_o,
  output pc_t    jal_target_o
);

  // Major opcodes
  localparam logic [6:0] opc_jal  = 7'b1101111;
  localparam logic [6:0] opc_jalr = 7'b1100111;

  logic [4:0] rd;
  logic [4:0] rs1;
  logic       rd_link;
  logic       rs1_link;
  pc_t        j_imm;

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////

  assign rd  = fetch_instr_i[11:7];
  assign rs1 = fetch_instr_i[19:15];

  assign is_jal_o  = (fetch_instr_i[6:0] == opc_jal);
  assign is_jalr_o = (fetch_instr_i[6:0] == opc_jalr);

  // x1 and x5 act as link registers
  assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
  assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

  //////////////////////////////////////////////////
  // Link hint table
  //////////////////////////////////////////////////

  always_comb begin
    push_o = 1'b0;
    pop_o  = 1'b0;
    if (is_jal_o) begin
      // No rs1 on JAL, so only a call is possible
      push_o = rd_link;
    end else if (is_jalr_o) begin
      // Push whenever rd links
      push_o = rd_link;
      // Pop on rs1 link unless rd is the same register
      pop_o  = rs1_link && !(rd_link && (rd == rs1));
    end
  end

  //////////////////////////////////////////////////
  // Addresses
  //////////////////////////////////////////////////

  // Return address of a call
  assign link_addr_o = fetch_pc_i + pc_t'(4);

  // J-immediate, sign extended from bit 31
  assign j_imm = {{(`BP_XLEN-20){fetch_instr_i[31]}},
                  fetch_instr_i[19:12],
                  fetch_instr_i[20],
                  fetch_instr_i[30:21],
                  1'b0};

  assign jal_target_o = fetch_pc_i + j_imm;

endmodule

// ==== rtl/bp_rsb.sv ====
//////////////////////////////////////////////////
// Return stack, top at entry 0, oldest dropped on overflow
// No repair after a mispredict; empty returns last push
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bp_cfg.svh"

module bp_rsb import bp_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ena_i,
  input  pc_t  d_i,
  input  logic push_i,
  input  logic pop_i,
  output pc_t  q_o,
  output logic empty_o
);

  // Count holds 0 up to the full depth
  localparam int unsigned cnt_w = $clog2(`BP_RSB_DEPTH + 1);

  pc_t              stack_q [`BP_RSB_DEPTH];
  pc_t              last_push_q;
  logic [cnt_w-1:0] cnt_q;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Fallback value for returns on an empty stack
  always_ff @(posedge clk_i) begin
    if (ena_i && push_i) begin
      last_push_q <= d_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ena_i) begin
      case ({push_i, pop_i})
        // Push shifts toward the bottom
        2'b10: begin
          stack_q[0] <= d_i;
          for (int n = 1; n < `BP_RSB_DEPTH; n++) begin
            stack_q[n] <= stack_q[n-1];
          end
        end
        // Pop shifts toward the top
        2'b01: begin
          for (int n = 0; n < `BP_RSB_DEPTH - 1; n++) begin
            stack_q[n] <= stack_q[n+1];
          end
        end
        // Coroutine swap overwrites the top
        2'b11: stack_q[0] <= d_i;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (ena_i) begin
      case ({push_i, pop_i})
        // Saturates at depth
        2'b10: if (cnt_q != cnt_w'(`BP_RSB_DEPTH)) cnt_q <= cnt_q + 1'b1;
        2'b01: if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
        // Pop on empty is a no-op, so the push still lands
        2'b11: if (cnt_q == '0) cnt_q <= cnt_w'(1);
        default: ;
      endcase
    end
  end

  assign empty_o = (cnt_q == '0);

  // Top of stack or the last pushed address
  assign q_o = empty_o ? last_push_q : stack_q[0];

endmodule

// ==== rtl/bp_btb.sv ====
//////////////////////////////////////////////////
// Direct-mapped BTB, one target per word-aligned PC
// Updates land at the next edge; same-cycle lookup sees old data
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bp_cfg.svh"

module bp_btb import bp_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  // Lookup port from fetch
  input  pc_t  lookup_pc_i,
  output logic hit_o,
  output pc_t  target_o,

  // Update port from execute
  input  logic upd_vld_i,
  input  pc_t  upd_pc_i,
  input  pc_t  upd_target_i
);

  //////////////////////////////////////////////////
  // Arrays
  //////////////////////////////////////////////////

  // Valid is the only state cleared by reset
  logic [`BP_BTB_ENTRIES-1:0] valid_q;
  btb_tag_t                   tag_q    [`BP_BTB_ENTRIES];
  pc_t                        target_q [`BP_BTB_ENTRIES];

  btb_idx_t lookup_idx;
  btb_tag_t lookup_tag;
  btb_idx_t upd_idx;
  btb_tag_t upd_tag;

  //////////////////////////////////////////////////
  // PC slicing
  //////////////////////////////////////////////////

  // Bits 1:0 are always zero for 32-bit instructions
  assign lookup_idx = lookup_pc_i[`BP_BTB_IDX_W+1:2];
  assign lookup_tag = lookup_pc_i[`BP_XLEN-1:`BP_BTB_IDX_W+2];

  assign upd_idx = upd_pc_i[`BP_BTB_IDX_W+1:2];
  assign upd_tag = upd_pc_i[`BP_XLEN-1:`BP_BTB_IDX_W+2];

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////

  // Hit needs a valid entry and a full tag match
  assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign target_o = target_q[lookup_idx];

  //////////////////////////////////////////////////
  // Update
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (upd_vld_i) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Replace whatever sat at this index
  always_ff @(posedge clk_i) begin
    if (upd_vld_i) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= upd_target_i;
    end
  end

endmodule

// ==== rtl/bp_next_pc.sv ====
//////////////////////////////////////////////////
// Fixed-priority next PC select, fully combinational
// BTB hit counts as taken; no direction predictor
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bp_cfg.svh"

module bp_next_pc import bp_pkg::*; (
  input  pc_t  fetch_pc_i,

  // Candidate targets
  input  pc_t  rsb_q_i,
  input  pc_t  jal_target_i,
  input  pc_t  btb_target_i,

  // Select qualifiers
  input  logic pop_i,
  input  logic is_jal_i,
  input  logic btb_hit_i,

  output pc_t  npc_o
);

  pc_t seq_pc;

  //////////////////////////////////////////////////
  // Fall-through
  //////////////////////////////////////////////////

  // Next sequential word
  assign seq_pc = fetch_pc_i + pc_t'(4);

  //////////////////////////////////////////////////
  // Priority select
  //////////////////////////////////////////////////

  // pop_i only rises for JALR returns and swaps
  always_comb begin
    if (pop_i) begin
      // Return address from the stack
      npc_o = rsb_q_i;
    end else if (is_jal_i) begin
      // Direct jump, target known at decode
      npc_o = jal_target_i;
    end else if (btb_hit_i) begin
      // Branches and non-return JALR
      npc_o = btb_target_i;
    end else begin
      npc_o = seq_pc;
    end
  end

endmodule

// ==== rtl/bp_top.sv ====
//////////////////////////////////////////////////
// Next-fetch-address predictor, one instruction per cycle
// npc_o is valid only while fetch_vld_i is high
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bp_cfg.svh"

module bp_top import bp_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,

  // Fetch group
  input  logic   fetch_vld_i,
  input  pc_t    fetch_pc_i,
  input  instr_t fetch_instr_i,

  // Resolved taken targets from execute
  input  logic   upd_vld_i,
  input  pc_t    upd_pc_i,
  input  pc_t    upd_target_i,

  output pc_t    npc_o,
  output logic   rsb_empty_o
);

  logic push;
  logic pop;
  logic is_jal;
  pc_t  link_addr;
  pc_t  jal_target;
  pc_t  rsb_q;
  logic btb_hit;
  pc_t  btb_target;

  //////////////////////////////////////////////////
  // Predecode
  //////////////////////////////////////////////////

  // JALR flag left open since pop already implies JALR
  bp_link_decode i_link_decode (
    .fetch_instr_i (fetch_instr_i),
    .fetch_pc_i    (fetch_pc_i),
    .push_o        (push),
    .pop_o         (pop),
    .is_jal_o      (is_jal),
    .is_jalr_o     (),
    .link_addr_o   (link_addr),
    .jal_target_o  (jal_target)
  );

  //////////////////////////////////////////////////
  // Return stack and BTB
  //////////////////////////////////////////////////

  // Stack only moves on a valid fetch
  bp_rsb i_rsb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .ena_i   (fetch_vld_i),
    .d_i     (link_addr),
    .push_i  (push),
    .pop_i   (pop),
    .q_o     (rsb_q),
    .empty_o (rsb_empty_o)
  );

  bp_btb i_btb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lookup_pc_i  (fetch_pc_i),
    .hit_o        (btb_hit),
    .target_o     (btb_target),
    .upd_vld_i    (upd_vld_i),
    .upd_pc_i     (upd_pc_i),
    .upd_target_i (upd_target_i)
  );

  //////////////////////////////////////////////////
  // Selector
  //////////////////////////////////////////////////

  bp_next_pc i_next_pc (
    .fetch_pc_i   (fetch_pc_i),
    .rsb_q_i      (rsb_q),
    .jal_target_i (jal_target),
    .btb_target_i (btb_target),
    .pop_i        (pop),
    .is_jal_i     (is_jal),
    .btb_hit_i    (btb_hit),
    .npc_o        (npc_o)
  );

endmodule

// ==== dv/bp_tb.sv ====
//////////////////////////////////////////////////
// Model-based self-checking testbench for bp_top
// Checks npc_o and rsb_empty_o only while fetch_vld_i is high
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "bp_cfg.svh"

module bp_tb import bp_pkg::*; ();

  // Cycles per test in run order from sequential to BTB
  localparam int reset_cycles = 16;
  localparam int test_cycles  = 5 + 6 + (2 * `BP_RSB_DEPTH + 2) + 13 + 7 + 9;
  localparam int cycle_limit  = reset_cycles + test_cycles + 20;

  logic   clk_i;
  logic   rst_ni;
  logic   fetch_vld_i;
  pc_t    fetch_pc_i;
  instr_t fetch_instr_i;
  logic   upd_vld_i;
  pc_t    upd_pc_i;
  pc_t    upd_target_i;
  pc_t    npc_o;
  logic   rsb_empty_o;

  logic [15:0] lfsr_q;
  int          err_cnt;
  int          chk_cnt;
  int          cycle_cnt;
  int          test_num;
  int          test_err_base;

  // Reference model state
  pc_t  m_stack   [`BP_RSB_DEPTH];
  int   m_cnt;
  pc_t  m_last;
  logic m_btb_vld [`BP_BTB_ENTRIES];
  pc_t  m_btb_tag [`BP_BTB_ENTRIES];
  pc_t  m_btb_tgt [`BP_BTB_ENTRIES];
  pc_t  exp_npc;
  logic exp_empty;
  logic [1:0] exp_hint;
  int   exp_idx;

  bp_top i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_vld_i   (fetch_vld_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_instr_i (fetch_instr_i),
    .upd_vld_i     (upd_vld_i),
    .upd_pc_i      (upd_pc_i),
    .upd_target_i  (upd_target_i),
    .npc_o         (npc_o),
    .rsb_empty_o   (rsb_empty_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic rand_pc(output pc_t pc);
    logic [31:0] v;
    draw(30, v);
    pc = {v[29:0], 2'b00};
  endtask

  task automatic rand_jimm(output logic [20:0] imm);
    logic [31:0] v;
    draw(20, v);
    imm = {v[19:0], 1'b0};
  endtask

  // Either x1 or x5
  task automatic rand_link(output logic [4:0] r);
    logic [31:0] v;
    draw(1, v);
    r = v[0] ? 5'd5 : 5'd1;
  endtask

  function automatic instr_t enc_jal(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic instr_t enc_jalr(logic [4:0] rd, logic [4:0] rs1);
    return {12'd0, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  // addi x2, x2, 1 and beq x2, x3 as filler
  function automatic instr_t enc_addi();
    return {12'd1, 5'd2, 3'b000, 5'd2, 7'b0010011};
  endfunction

  function automatic instr_t enc_beq();
    return {7'd0, 5'd3, 5'd2, 3'b000, 5'd8, 7'b1100011};
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic is_link(logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  // Returns {push, pop} from the RISC-V hint table
  function automatic logic [1:0] link_hint(instr_t ins);
    logic [4:0] rd;
    logic [4:0] rs1;
    rd  = ins[11:7];
    rs1 = ins[19:15];
    if (ins[6:0] == 7'b1101111) return {is_link(rd), 1'b0};
    if (ins[6:0] != 7'b1100111) return 2'b00;
    case ({is_link(rd), is_link(rs1)})
      2'b10: return 2'b10;
      2'b01: return 2'b01;
      2'b11: return (rd == rs1) ? 2'b10 : 2'b11;
      default: return 2'b00;
    endcase
  endfunction

  // J-type immediate bit by bit as the ISA places it
  function automatic pc_t j_imm_of(instr_t ins);
    logic [20:0] imm;
    imm[20]    = ins[31];
    imm[19:12] = ins[19:12];
    imm[11]    = ins[20];
    imm[10:1]  = ins[30:21];
    imm[0]     = 1'b0;
    return {{(`BP_XLEN-21){imm[20]}}, imm};
  endfunction

  function automatic int btb_index(pc_t pc);
    return int'((pc >> 2) % pc_t'(`BP_BTB_ENTRIES));
  endfunction

  function automatic pc_t btb_tag_of(pc_t pc);
    return pc >> (2 + $clog2(`BP_BTB_ENTRIES));
  endfunction

  // Predicted next PC in priority order
  always_comb begin
    exp_hint  = link_hint(fetch_instr_i);
    exp_idx   = btb_index(fetch_pc_i);
    exp_empty = (m_cnt == 0);
    if (exp_hint[0]) begin
      exp_npc = (m_cnt > 0) ? m_stack[0] : m_last;
    end else if (fetch_instr_i[6:0] == 7'b1101111) begin
      exp_npc = fetch_pc_i + j_imm_of(fetch_instr_i);
    end else if (m_btb_vld[exp_idx] && (m_btb_tag[exp_idx] == btb_tag_of(fetch_pc_i))) begin
      exp_npc = m_btb_tgt[exp_idx];
    end else begin
      exp_npc = fetch_pc_i + 4;
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_cnt <= 0;
      for (int i = 0; i < `BP_BTB_ENTRIES; i++) m_btb_vld[i] <= 1'b0;
    end else begin
      if (fetch_vld_i) begin
        case (link_hint(fetch_instr_i))
          // Call drops the oldest entry off the bottom
          2'b10: begin
            m_stack[0] <= fetch_pc_i + 4;
            for (int i = 1; i < `BP_RSB_DEPTH; i++) m_stack[i] <= m_stack[i-1];
            m_cnt  <= (m_cnt < `BP_RSB_DEPTH) ? m_cnt + 1 : `BP_RSB_DEPTH;
            m_last <= fetch_pc_i + 4;
          end
          2'b01: begin
            for (int i = 0; i < `BP_RSB_DEPTH - 1; i++) m_stack[i] <= m_stack[i+1];
            m_cnt <= (m_cnt > 0) ? m_cnt - 1 : 0;
          end
          // Swap replaces the top and leaves at least one entry
          2'b11: begin
            m_stack[0] <= fetch_pc_i + 4;
            m_cnt  <= (m_cnt > 0) ? m_cnt : 1;
            m_last <= fetch_pc_i + 4;
          end
          default: ;
        endcase
      end
      if (upd_vld_i) begin
        m_btb_vld[btb_index(upd_pc_i)] <= 1'b1;
        m_btb_tag[btb_index(upd_pc_i)] <= btb_tag_of(upd_pc_i);
        m_btb_tgt[btb_index(upd_pc_i)] <= upd_target_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  function automatic void report_mismatch(string what, pc_t got, pc_t exp);
    err_cnt++;
    $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
  endfunction

  npc_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_vld_i |-> (npc_o == exp_npc))
    else report_mismatch("npc_o", $sampled(npc_o), $sampled(exp_npc));

  empty_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_vld_i |-> (rsb_empty_o == exp_empty))
    else report_mismatch("rsb_empty_o", pc_t'($sampled(rsb_empty_o)),
                         pc_t'($sampled(exp_empty)));

  always @(posedge clk_i) begin
    if (rst_ni && fetch_vld_i) chk_cnt++;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  task automatic step(input logic vld, input pc_t pc, input instr_t ins,
                      input logic uvld, input pc_t upc, input pc_t utgt);
    @(posedge clk_i);
    fetch_vld_i   <= vld;
    fetch_pc_i    <= pc;
    fetch_instr_i <= ins;
    upd_vld_i     <= uvld;
    upd_pc_i      <= upc;
    upd_target_i  <= utgt;
  endtask

  task automatic fetch(input pc_t pc, input instr_t ins);
    step(1'b1, pc, ins, 1'b0, '0, '0);
  endtask

  // Idle cycle lets the last check fire before the report
  task automatic end_test(input string name);
    step(1'b0, '0, enc_addi(), 1'b0, '0, '0);
    @(negedge clk_i);
    test_num++;
    $display("Test %0d %s done: %0d errors", test_num, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_seq();
    pc_t pc;
    for (int k = 0; k < 4; k++) begin
      rand_pc(pc);
      fetch(pc, enc_addi());
    end
    end_test("sequential");
  endtask

  task automatic test_jal();
    pc_t         pc;
    logic [20:0] imm;
    rand_pc(pc);
    rand_jimm(imm);
    fetch(pc, enc_jal(5'd1, imm));
    rand_pc(pc);
    rand_jimm(imm);
    fetch(pc, enc_jal(5'd0, imm));
    rand_pc(pc);
    rand_jimm(imm);
    fetch(pc, enc_jal(5'd5, imm));
    // Second return sees the x1 call, not the x0 jump
    rand_pc(pc);
    fetch(pc, enc_jalr(5'd0, 5'd1));
    rand_pc(pc);
    fetch(pc, enc_jalr(5'd0, 5'd5));
    end_test("jal");
  endtask

  task automatic test_nested();
    pc_t         pc;
    logic [20:0] imm;
    logic [4:0]  r;
    for (int k = 0; k < `BP_RSB_DEPTH; k++) begin
      rand_pc(pc);
      rand_jimm(imm);
      rand_link(r);
      fetch(pc, enc_jal(r, imm));
    end
    // Returns come back in reverse order
    for (int k = 0; k < `BP_RSB_DEPTH; k++) begin
      rand_pc(pc);
      rand_link(r);
      fetch(pc, enc_jalr(5'd0, r));
    end
    // Stack reads empty after the last return
    rand_pc(pc);
    fetch(pc, enc_addi());
    end_test("nested");
  endtask

  task automatic test_overflow();
    pc_t         pc;
    logic [20:0] imm;
    for (int k = 0; k < 6; k++) begin
      rand_pc(pc);
      rand_jimm(imm);
      fetch(pc, enc_jal(5'd1, imm));
    end
    // Last two returns hit an empty stack
    for (int k = 0; k < 6; k++) begin
      rand_pc(pc);
      fetch(pc, enc_jalr(5'd0, 5'd1));
    end
    end_test("overflow");
  endtask

  task automatic test_swap();
    pc_t         pc;
    logic [20:0] imm;
    for (int k = 0; k < 2; k++) begin
      rand_pc(pc);
      rand_jimm(imm);
      fetch(pc, enc_jal(5'd1, imm));
    end
    rand_pc(pc);
    fetch(pc, enc_jalr(5'd1, 5'd5));
    rand_pc(pc);
    fetch(pc, enc_jalr(5'd0, 5'd1));
    // Same link register on both sides pushes only
    rand_pc(pc);
    fetch(pc, enc_jalr(5'd1, 5'd1));
    rand_pc(pc);
    fetch(pc, enc_jalr(5'd0, 5'd5));
    end_test("swap");
  endtask

  task automatic test_btb();
    pc_t pc;
    pc_t alias_pc;
    pc_t jr_pc;
    pc_t tgt;
    pc_t tgt2;
    rand_pc(pc);
    rand_pc(tgt);
    rand_pc(tgt2);
    rand_pc(jr_pc);
    // Same index with the tag differing in the top bit
    alias_pc = pc ^ 32'h8000_0000;
    step(1'b1, pc, enc_beq(), 1'b1, pc, tgt);
    fetch(pc, enc_beq());
    fetch(alias_pc, enc_beq());
    step(1'b1, pc, enc_beq(), 1'b1, alias_pc, tgt2);
    fetch(alias_pc, enc_beq());
    fetch(pc, enc_beq());
    // Non-return JALR through the BTB
    step(1'b1, pc, enc_addi(), 1'b1, jr_pc, tgt);
    fetch(jr_pc, enc_jalr(5'd0, 5'd6));
    end_test("btb");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_ni        = 1'b0;
    fetch_vld_i   = 1'b0;
    fetch_pc_i    = '0;
    fetch_instr_i = enc_addi();
    upd_vld_i     = 1'b0;
    upd_pc_i      = '0;
    upd_target_i  = '0;
    lfsr_q        = 16'd11;
    err_cnt       = 0;
    chk_cnt       = 0;
    cycle_cnt     = 0;
    test_num      = 0;
    test_err_base = 0;
    repeat (reset_cycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_seq();
    test_jal();
    test_nested();
    test_overflow();
    test_swap();
    test_btb();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_num, chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/bp_pkg.sv
rtl/bp_link_decode.sv
rtl/bp_rsb.sv
rtl/bp_btb.sv
rtl/bp_next_pc.sv
rtl/bp_top.sv
dv/bp_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= bp_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Regression passed" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
